//--- source/ccipPkg.sv
// CCI-P channel 1 transmit types
// Write-line request header and the line that carries it toward the host
package ccipPkg;

    localparam int CL_ADDR_WIDTH = 42;
    localparam int CL_DATA_WIDTH = 512;

    typedef logic [CL_ADDR_WIDTH-1:0] ClAddr;

    // Number of lines in a multi-line write
    typedef enum logic [1:0] {
        eClLen1 = 2'b00,
        eClLen2 = 2'b01,
        eClLen4 = 2'b11
    } ClLen;

    typedef enum logic [3:0] {
        eReqWrLineI = 4'h0,
        eReqWrLineM = 4'h1,
        eReqWrFence = 4'h4
    } ReqType;

    typedef struct packed {
        ReqType reqType;
        ClLen   clLen;
        logic   sop;
        ClAddr  address;
    } C1TxHdr;

    typedef struct packed {
        logic                     valid;
        C1TxHdr                   hdr;
        logic [CL_DATA_WIDTH-1:0] data;
    } C1Tx;

endpackage

//--- source/nicTxPkg.sv
// NIC transmit path definitions
// Sizes of the flow FIFOs and the request queue, plus the request and
// the internal transfer structs between queue, scheduler and writer
package nicTxPkg;

    localparam int L_MAX_FLOWS  = 2;
    localparam int MAX_FLOWS    = 1 << L_MAX_FLOWS;

    localparam int L_FIFO_DEPTH = 3;
    localparam int FIFO_DEPTH   = 1 << L_FIFO_DEPTH;

    localparam int L_SLOTS      = 5;
    localparam int SLOTS        = 1 << L_SLOTS;

    // Largest batch is 4 lines
    localparam int L_MAX_BATCH  = 2;

    typedef logic [L_MAX_FLOWS-1:0]  FlowId;
    typedef logic [L_SLOTS-1:0]      SlotId;
    typedef logic [L_MAX_BATCH:0]    BatchCnt;
    typedef logic [L_FIFO_DEPTH:0]   FifoCnt;

    typedef struct packed {
        logic [15:0] rpcId;
        logic [47:0] arg;
    } RpcReq;

    // Travels with each read so the writer knows flow and beat
    typedef struct packed {
        FlowId                  flow;
        logic [L_MAX_BATCH-1:0] beat;
    } TxTag;

    typedef struct packed {
        logic  valid;
        SlotId slot;
        TxTag  tag;
    } RqRead;

    typedef struct packed {
        logic  valid;
        RpcReq req;
        TxTag  tag;
    } RqResp;

    typedef struct packed {
        logic [MAX_FLOWS-1:0] en;
        SlotId                slot;
    } FlowPush;

endpackage

//--- source/flowFifo.sv
// Per-flow FIFO of slot numbers
// Show-ahead circular buffer, head is valid whenever count is nonzero
`timescale 1ns/1ns

module flowFifo (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  nicTxPkg::SlotId  pushSlot,
    input  logic             pop,
    output nicTxPkg::SlotId  head,
    output nicTxPkg::FifoCnt count
);

    nicTxPkg::SlotId                 entries [nicTxPkg::FIFO_DEPTH];
    logic [nicTxPkg::L_FIFO_DEPTH-1:0] wrPtr;
    logic [nicTxPkg::L_FIFO_DEPTH-1:0] rdPtr;

    assign head = entries[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= pushSlot;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    aNoOverflow: assert property (@(posedge clk) disable iff (reset)
        push |-> (count != nicTxPkg::FifoCnt'(nicTxPkg::FIFO_DEPTH)));

    aNoUnderflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> (count != '0));

endmodule

//--- source/requestQueue.sv
// Shared request queue
// Stores accepted requests in free slots, steers slot numbers to the
// flow FIFOs and answers tagged reads one cycle later
`timescale 1ns/1ns

module requestQueue (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              rpcValid,
    input  nicTxPkg::RpcReq   rpcIn,
    input  nicTxPkg::FlowId   rpcFlowId,
    input  nicTxPkg::FifoCnt  flowCount [nicTxPkg::MAX_FLOWS],
    output nicTxPkg::FlowPush flowPush,
    input  nicTxPkg::RqRead   rdReq,
    output nicTxPkg::RqResp   rdResp,
    output logic              dropped
);

    nicTxPkg::RpcReq                 mem [nicTxPkg::SLOTS];
    logic [nicTxPkg::SLOTS-1:0]      freeMap;
    nicTxPkg::SlotId                 freeSlot;
    logic                            anyFree;
    logic [nicTxPkg::MAX_FLOWS-1:0]  fifoFull;
    logic [nicTxPkg::MAX_FLOWS-1:0]  pushEn;
    logic                            accept;

    logic                            respValid;
    nicTxPkg::RpcReq                 respReq;
    nicTxPkg::TxTag                  respTag;

    // Lowest free slot wins
    always_comb begin
        freeSlot = '0;
        anyFree  = 1'b0;
        for (int i = nicTxPkg::SLOTS - 1; i >= 0; i--) begin
            if (freeMap[i]) begin
                freeSlot = nicTxPkg::SlotId'(i);
                anyFree  = 1'b1;
            end
        end
    end

    always_comb begin
        for (int f = 0; f < nicTxPkg::MAX_FLOWS; f++) begin
            fifoFull[f] = flowCount[f] == nicTxPkg::FifoCnt'(nicTxPkg::FIFO_DEPTH);
        end
    end

    assign accept  = start && rpcValid && anyFree && !fifoFull[rpcFlowId];
    assign dropped = start && rpcValid && !accept;

    always_comb begin
        for (int f = 0; f < nicTxPkg::MAX_FLOWS; f++) begin
            pushEn[f] = accept && (rpcFlowId == nicTxPkg::FlowId'(f));
        end
    end

    assign flowPush = '{en: pushEn, slot: freeSlot};

    always_ff @(posedge clk) begin
        if (reset) begin
            freeMap <= '1;
        end else begin
            if (accept) begin
                freeMap[freeSlot] <= 1'b0;
            end
            // Slot is released as its entry is read out
            if (rdReq.valid) begin
                freeMap[rdReq.slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[freeSlot] <= rpcIn;
        end
        respReq <= mem[rdReq.slot];
        respTag <= rdReq.tag;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            respValid <= 1'b0;
        end else begin
            respValid <= rdReq.valid;
        end
    end

    assign rdResp = '{valid: respValid, req: respReq, tag: respTag};

    aReadAllocated: assert property (@(posedge clk) disable iff (reset)
        rdReq.valid |-> !freeMap[rdReq.slot]);

    aNoAllocFree: assert property (@(posedge clk) disable iff (reset)
        (accept && rdReq.valid) |-> (freeSlot != rdReq.slot));

endmodule

//--- source/batchScheduler.sv
// Round-robin batch scheduler
// Scans the flows for a full batch, then pops it one entry per cycle
// and issues the matching request queue reads
`timescale 1ns/1ns

module batchScheduler (
    input  logic                           clk,
    input  logic                           reset,
    input  nicTxPkg::FlowId                numberOfFlows,
    input  logic [1:0]                     lBatchSize,
    input  logic                           almFull,
    input  nicTxPkg::FifoCnt               flowCount [nicTxPkg::MAX_FLOWS],
    input  nicTxPkg::SlotId                flowHead [nicTxPkg::MAX_FLOWS],
    output logic [nicTxPkg::MAX_FLOWS-1:0] flowPop,
    output nicTxPkg::RqRead                rdReq
);

    typedef enum logic {
        StIdle,
        StTransmit
    } SchedState;

    SchedState         state;
    nicTxPkg::FlowId   flowPtr;
    nicTxPkg::BatchCnt batchSize;
    nicTxPkg::BatchCnt beatCnt;
    logic              startBatch;
    logic              lastBeat;

    logic              readValid;
    nicTxPkg::SlotId   readSlot;
    nicTxPkg::TxTag    readTag;

    assign batchSize = nicTxPkg::BatchCnt'(1) << lBatchSize;

    // New batches wait for the host side to drain
    assign startBatch = (state == StIdle) && !almFull
        && (flowCount[flowPtr] >= nicTxPkg::FifoCnt'(batchSize));
    assign lastBeat = beatCnt == batchSize - 1'b1;

    always_comb begin
        flowPop = '0;
        if (state == StTransmit) begin
            flowPop[flowPtr] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= StIdle;
            flowPtr <= '0;
            beatCnt <= '0;
        end else begin
            case (state)
                StIdle: begin
                    if (startBatch) begin
                        state   <= StTransmit;
                        beatCnt <= '0;
                    end else if (flowPtr >= numberOfFlows) begin
                        flowPtr <= '0;
                    end else begin
                        flowPtr <= flowPtr + 1'b1;
                    end
                end
                StTransmit: begin
                    if (lastBeat) begin
                        state   <= StIdle;
                        beatCnt <= '0;
                    end else begin
                        beatCnt <= beatCnt + 1'b1;
                    end
                end
                default: state <= StIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            readValid <= 1'b0;
        end else begin
            readValid <= |flowPop;
        end
    end

    always_ff @(posedge clk) begin
        readSlot <= flowHead[flowPtr];
        readTag  <= '{flow: flowPtr, beat: beatCnt[nicTxPkg::L_MAX_BATCH-1:0]};
    end

    assign rdReq = '{valid: readValid, slot: readSlot, tag: readTag};

    // Granted flow still holds the rest of its batch
    aBatchAvailable: assert property (@(posedge clk) disable iff (reset)
        (state == StTransmit)
            |-> (flowCount[flowPtr] >= nicTxPkg::FifoCnt'(batchSize - beatCnt)));

endmodule

//--- source/clWriter.sv
// Cache-line writer
// Turns queue read results into registered CCI-P write-line requests
`timescale 1ns/1ns

module clWriter (
    input  logic            clk,
    input  logic            reset,
    input  ccipPkg::ClAddr  txBaseAddr,
    input  logic [1:0]      lBatchSize,
    input  nicTxPkg::RqResp rdResp,
    output ccipPkg::C1Tx    c1Tx
);

    ccipPkg::ClLen                     clLen;
    ccipPkg::ClAddr                    lineAddr;
    ccipPkg::C1TxHdr                   nextHdr;
    logic [ccipPkg::CL_DATA_WIDTH-1:0] nextData;

    logic                              lineValid;
    ccipPkg::C1TxHdr                   lineHdr;
    logic [ccipPkg::CL_DATA_WIDTH-1:0] lineData;

    always_comb begin
        case (lBatchSize)
            2'd0:    clLen = ccipPkg::eClLen1;
            2'd1:    clLen = ccipPkg::eClLen2;
            default: clLen = ccipPkg::eClLen4;
        endcase
    end

    // Each flow owns a block of batch-size lines above the base
    assign lineAddr = txBaseAddr
        + (ccipPkg::ClAddr'(rdResp.tag.flow) << lBatchSize)
        + ccipPkg::ClAddr'(rdResp.tag.beat);

    assign nextHdr = '{reqType: ccipPkg::eReqWrLineI, clLen: clLen,
                       sop: rdResp.tag.beat == '0, address: lineAddr};

    always_comb begin
        nextData = '0;
        nextData[$bits(nicTxPkg::RpcReq)-1:0] = rdResp.req;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lineValid <= 1'b0;
        end else begin
            lineValid <= rdResp.valid;
        end
    end

    always_ff @(posedge clk) begin
        lineHdr  <= nextHdr;
        lineData <= nextData;
    end

    assign c1Tx = '{valid: lineValid, hdr: lineHdr, data: lineData};

    aBatchSizeRange: assert property (@(posedge clk) disable iff (reset)
        lBatchSize <= 2'd2);

endmodule

//--- source/ccipTransmitter.sv
// CPU-to-NIC transmit path
// Request queue and flow FIFOs feed a batch scheduler whose reads
// leave as batched CCI-P write lines
`timescale 1ns/1ns

module ccipTransmitter (
    input  logic            clk,
    input  logic            reset,
    input  nicTxPkg::FlowId numberOfFlows,
    input  ccipPkg::ClAddr  txBaseAddr,
    input  logic [1:0]      lBatchSize,
    input  logic            start,
    input  nicTxPkg::RpcReq rpcIn,
    input  logic            rpcValid,
    input  nicTxPkg::FlowId rpcFlowId,
    input  logic            c1AlmFull,
    output ccipPkg::C1Tx    c1Tx,
    output logic            txReady,
    output logic            pdropTxFlows
);

    nicTxPkg::FlowPush              flowPush;
    nicTxPkg::FifoCnt               flowCount [nicTxPkg::MAX_FLOWS];
    nicTxPkg::SlotId                flowHead [nicTxPkg::MAX_FLOWS];
    logic [nicTxPkg::MAX_FLOWS-1:0] flowPop;
    nicTxPkg::RqRead                rdReq;
    nicTxPkg::RqResp                rdResp;

    assign txReady = ~c1AlmFull;

    requestQueue u_requestQueue (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .rpcValid  (rpcValid),
        .rpcIn     (rpcIn),
        .rpcFlowId (rpcFlowId),
        .flowCount (flowCount),
        .flowPush  (flowPush),
        .rdReq     (rdReq),
        .rdResp    (rdResp),
        .dropped   (pdropTxFlows)
    );

    for (genvar g = 0; g < nicTxPkg::MAX_FLOWS; g++) begin : gFlow
        flowFifo u_flowFifo (
            .clk      (clk),
            .reset    (reset),
            .push     (flowPush.en[g]),
            .pushSlot (flowPush.slot),
            .pop      (flowPop[g]),
            .head     (flowHead[g]),
            .count    (flowCount[g])
        );
    end

    batchScheduler u_batchScheduler (
        .clk           (clk),
        .reset         (reset),
        .numberOfFlows (numberOfFlows),
        .lBatchSize    (lBatchSize),
        .almFull       (c1AlmFull),
        .flowCount     (flowCount),
        .flowHead      (flowHead),
        .flowPop       (flowPop),
        .rdReq         (rdReq)
    );

    clWriter u_clWriter (
        .clk        (clk),
        .reset      (reset),
        .txBaseAddr (txBaseAddr),
        .lBatchSize (lBatchSize),
        .rdResp     (rdResp),
        .c1Tx       (c1Tx)
    );

endmodule

//--- sim/tbTable.svh
// Stimulus table for the transmit path testbench
// One row per request, grouped into phases that each set their own configuration
`ifndef TB_TABLE_SVH
`define TB_TABLE_SVH

// Columns: phase, numberOfFlows, lBatchSize, base address, almFull,
// flow, rpcId, expected drop
typedef struct packed {
    logic [3:0]  phase;
    logic [1:0]  numFlows;
    logic [1:0]  lBatch;
    logic [41:0] base;
    logic        almFull;
    logic [1:0]  flow;
    logic [15:0] rpcId;
    logic        drop;
} StimRow;

localparam int NUM_ROWS = 33;

localparam StimRow STIM_TABLE [NUM_ROWS] = '{
    // Batch size 1 over four flows
    '{4'd0, 2'd3, 2'd0, 42'h1000, 1'b0, 2'd0, 16'h0101, 1'b0},
    '{4'd0, 2'd3, 2'd0, 42'h1000, 1'b0, 2'd1, 16'h0102, 1'b0},
    '{4'd0, 2'd3, 2'd0, 42'h1000, 1'b0, 2'd2, 16'h0103, 1'b0},
    '{4'd0, 2'd3, 2'd0, 42'h1000, 1'b0, 2'd3, 16'h0104, 1'b0},
    '{4'd0, 2'd3, 2'd0, 42'h1000, 1'b0, 2'd1, 16'h0105, 1'b0},
    // Batch size 2, partial batches wait, short almFull window
    '{4'd1, 2'd3, 2'd1, 42'h2000, 1'b0, 2'd0, 16'h0201, 1'b0},
    '{4'd1, 2'd3, 2'd1, 42'h2000, 1'b0, 2'd1, 16'h0202, 1'b0},
    '{4'd1, 2'd3, 2'd1, 42'h2000, 1'b1, 2'd0, 16'h0203, 1'b0},
    '{4'd1, 2'd3, 2'd1, 42'h2000, 1'b0, 2'd2, 16'h0204, 1'b0},
    '{4'd1, 2'd3, 2'd1, 42'h2000, 1'b0, 2'd1, 16'h0205, 1'b0},
    '{4'd1, 2'd3, 2'd1, 42'h2000, 1'b0, 2'd2, 16'h0206, 1'b0},
    // Batch size 4 on flows 1 and 2
    '{4'd2, 2'd3, 2'd2, 42'h30000, 1'b0, 2'd1, 16'h0301, 1'b0},
    '{4'd2, 2'd3, 2'd2, 42'h30000, 1'b0, 2'd1, 16'h0302, 1'b0},
    '{4'd2, 2'd3, 2'd2, 42'h30000, 1'b0, 2'd1, 16'h0303, 1'b0},
    '{4'd2, 2'd3, 2'd2, 42'h30000, 1'b0, 2'd2, 16'h0304, 1'b0},
    '{4'd2, 2'd3, 2'd2, 42'h30000, 1'b0, 2'd1, 16'h0305, 1'b0},
    '{4'd2, 2'd3, 2'd2, 42'h30000, 1'b0, 2'd2, 16'h0306, 1'b0},
    '{4'd2, 2'd3, 2'd2, 42'h30000, 1'b0, 2'd2, 16'h0307, 1'b0},
    '{4'd2, 2'd3, 2'd2, 42'h30000, 1'b0, 2'd2, 16'h0308, 1'b0},
    // Two active flows
    '{4'd3, 2'd1, 2'd0, 42'h400, 1'b0, 2'd0, 16'h0401, 1'b0},
    '{4'd3, 2'd1, 2'd0, 42'h400, 1'b0, 2'd1, 16'h0402, 1'b0},
    '{4'd3, 2'd1, 2'd0, 42'h400, 1'b0, 2'd1, 16'h0403, 1'b0},
    '{4'd3, 2'd1, 2'd0, 42'h400, 1'b0, 2'd0, 16'h0404, 1'b0},
    '{4'd3, 2'd1, 2'd0, 42'h400, 1'b0, 2'd1, 16'h0405, 1'b0},
    // Host back-pressure fills flow 2, ninth request overflows
    '{4'd4, 2'd3, 2'd0, 42'h800, 1'b1, 2'd2, 16'h0501, 1'b0},
    '{4'd4, 2'd3, 2'd0, 42'h800, 1'b1, 2'd2, 16'h0502, 1'b0},
    '{4'd4, 2'd3, 2'd0, 42'h800, 1'b1, 2'd2, 16'h0503, 1'b0},
    '{4'd4, 2'd3, 2'd0, 42'h800, 1'b1, 2'd2, 16'h0504, 1'b0},
    '{4'd4, 2'd3, 2'd0, 42'h800, 1'b1, 2'd2, 16'h0505, 1'b0},
    '{4'd4, 2'd3, 2'd0, 42'h800, 1'b1, 2'd2, 16'h0506, 1'b0},
    '{4'd4, 2'd3, 2'd0, 42'h800, 1'b1, 2'd2, 16'h0507, 1'b0},
    '{4'd4, 2'd3, 2'd0, 42'h800, 1'b1, 2'd2, 16'h0508, 1'b0},
    '{4'd4, 2'd3, 2'd0, 42'h800, 1'b1, 2'd2, 16'h0509, 1'b1}
};

`endif

//--- sim/tbCcipTransmitter.sv
// Testbench for the CCI-P transmit path
// Applies the request table, models per-flow batching and checks every line
`timescale 1ns/1ns

module tbCcipTransmitter;

    `include "tbTable.svh"

    localparam int SEED         = 32'h02e7b62d;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT  = 20 * NUM_ROWS + 200;

    typedef struct packed {
        nicTxPkg::RpcReq                  req;
        logic [nicTxPkg::L_MAX_BATCH-1:0] beat;
    } ExpLine;

    logic            clk;
    logic            reset;
    nicTxPkg::FlowId numberOfFlows;
    ccipPkg::ClAddr  txBaseAddr;
    logic [1:0]      lBatchSize;
    logic            start;
    nicTxPkg::RpcReq rpcIn;
    logic            rpcValid;
    nicTxPkg::FlowId rpcFlowId;
    logic            c1AlmFull;
    ccipPkg::C1Tx    c1Tx;
    logic            txReady;
    logic            pdropTxFlows;

    // Accepted requests waiting for a full batch, then lines due on c1Tx
    nicTxPkg::RpcReq pendQ [nicTxPkg::MAX_FLOWS][$];
    ExpLine          readyQ [nicTxPkg::MAX_FLOWS][$];
    int              mismatchCount = 0;
    int              otherCount = 0;
    int              cycleCount = 0;
    logic            prevValid = 1'b0;
    int              prevFlow = 0;
    int              prevBeat = 0;

    ccipTransmitter u_dut (
        .clk           (clk),
        .reset         (reset),
        .numberOfFlows (numberOfFlows),
        .txBaseAddr    (txBaseAddr),
        .lBatchSize    (lBatchSize),
        .start         (start),
        .rpcIn         (rpcIn),
        .rpcValid      (rpcValid),
        .rpcFlowId     (rpcFlowId),
        .c1AlmFull     (c1AlmFull),
        .c1Tx          (c1Tx),
        .txReady       (txReady),
        .pdropTxFlows  (pdropTxFlows)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, errors: %0d mismatches, %0d other failures",
                CYCLE_LIMIT, mismatchCount, otherCount);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic reportMismatch(input string name, input logic [511:0] expected,
                                  input logic [511:0] observed);
        mismatchCount++;
        $display("FAIL t=%0t %s expected=%0h observed=%0h", $time, name, expected, observed);
    endtask

    function automatic int linesPending();
        int total;
        total = 0;
        for (int f = 0; f < nicTxPkg::MAX_FLOWS; f++) begin
            total += readyQ[f].size();
        end
        return total;
    endfunction

    function automatic ccipPkg::ClLen expectedLen(input logic [1:0] lBatch);
        case (lBatch)
            2'd0:    return ccipPkg::eClLen1;
            2'd1:    return ccipPkg::eClLen2;
            default: return ccipPkg::eClLen4;
        endcase
    endfunction

    task automatic modelAccept(input int flow, input nicTxPkg::RpcReq req);
        int     batch;
        ExpLine line;
        batch = 1 << lBatchSize;
        pendQ[flow].push_back(req);
        // Lines are due only once the flow holds a whole batch
        if (pendQ[flow].size() == batch) begin
            for (int b = 0; b < batch; b++) begin
                line.req  = pendQ[flow][b];
                line.beat = 2'(b);
                readyQ[flow].push_back(line);
            end
            pendQ[flow].delete();
        end
    endtask

    task automatic checkLine();
        ccipPkg::ClAddr offset;
        ccipPkg::ClAddr expAddr;
        int             flow;
        ExpLine         expLine;
        logic [511:0]   expData;
        offset = c1Tx.hdr.address - txBaseAddr;
        flow   = int'(offset >> lBatchSize);
        if ((offset >> lBatchSize) > ccipPkg::ClAddr'(numberOfFlows)) begin
            otherCount++;
            $display("Line at address %0h lies outside the active flows", c1Tx.hdr.address);
        end else if (readyQ[flow].size() == 0) begin
            otherCount++;
            $display("Unexpected line for flow %0d, no complete batch pending", flow);
        end else begin
            expLine = readyQ[flow].pop_front();
            expAddr = txBaseAddr + (ccipPkg::ClAddr'(flow) << lBatchSize)
                + ccipPkg::ClAddr'(expLine.beat);
            expData = '0;
            expData[63:0] = expLine.req;
            if (c1Tx.hdr.address !== expAddr) begin
                reportMismatch("c1Tx.hdr.address", expAddr, c1Tx.hdr.address);
            end
            if (c1Tx.data !== expData) begin
                reportMismatch("c1Tx.data", expData, c1Tx.data);
            end
            if (c1Tx.hdr.sop !== (expLine.beat == '0)) begin
                reportMismatch("c1Tx.hdr.sop", expLine.beat == '0, c1Tx.hdr.sop);
            end
            if (c1Tx.hdr.clLen !== expectedLen(lBatchSize)) begin
                reportMismatch("c1Tx.hdr.clLen", expectedLen(lBatchSize), c1Tx.hdr.clLen);
            end
            if (c1Tx.hdr.reqType !== ccipPkg::eReqWrLineI) begin
                reportMismatch("c1Tx.hdr.reqType", ccipPkg::eReqWrLineI, c1Tx.hdr.reqType);
            end
            // Later beats follow the earlier beat of the same flow directly
            if (expLine.beat != 0 && !(prevValid && prevFlow == flow
                    && prevBeat == int'(expLine.beat) - 1)) begin
                otherCount++;
                $display("Beat %0d of flow %0d did not follow its previous beat",
                    expLine.beat, flow);
            end
            prevFlow = flow;
            prevBeat = int'(expLine.beat);
        end
    endtask

    always @(negedge clk) begin
        if (txReady !== !c1AlmFull) begin
            reportMismatch("txReady", !c1AlmFull, txReady);
        end
        if (reset && cycleCount > 1) begin
            if (c1Tx.valid !== 1'b0) begin
                reportMismatch("c1Tx.valid", 1'b0, c1Tx.valid);
            end
            if (pdropTxFlows !== 1'b0) begin
                reportMismatch("pdropTxFlows", 1'b0, pdropTxFlows);
            end
        end else if (!reset && c1Tx.valid === 1'b1) begin
            checkLine();
        end
        prevValid = !reset && c1Tx.valid === 1'b1;
    end

    task automatic applyConfig(input StimRow row);
        numberOfFlows = row.numFlows;
        lBatchSize    = row.lBatch;
        txBaseAddr    = row.base;
    endtask

    task automatic applyRow(input StimRow row);
        nicTxPkg::RpcReq req;
        req.rpcId = row.rpcId;
        req.arg   = {16'($urandom), $urandom};
        rpcIn     = req;
        rpcFlowId = row.flow;
        rpcValid  = 1'b1;
        c1AlmFull = row.almFull;
        @(negedge clk);
        if (pdropTxFlows !== row.drop) begin
            reportMismatch("pdropTxFlows", row.drop, pdropTxFlows);
        end
        if (!row.drop) begin
            modelAccept(int'(row.flow), req);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic drainPhase();
        rpcValid  = 1'b0;
        c1AlmFull = 1'b0;
        while (linesPending() > 0) begin
            @(posedge clk);
        end
        // Quiet gap so that a stray line still shows up
        repeat (8) @(posedge clk);
        for (int f = 0; f < nicTxPkg::MAX_FLOWS; f++) begin
            if (pendQ[f].size() != 0) begin
                otherCount++;
                $display("Flow %0d ended its phase with %0d requests of an incomplete batch",
                    f, pendQ[f].size());
                pendQ[f].delete();
            end
        end
        #2;
    endtask

    initial begin
        int curPhase;
        void'($urandom(SEED));
        reset         = 1'b1;
        start         = 1'b0;
        rpcValid      = 1'b0;
        rpcIn         = '0;
        rpcFlowId     = '0;
        c1AlmFull     = 1'b0;
        numberOfFlows = '0;
        txBaseAddr    = '0;
        lBatchSize    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset    = 1'b0;
        start    = 1'b1;
        curPhase = -1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (int'(STIM_TABLE[i].phase) != curPhase) begin
                drainPhase();
                applyConfig(STIM_TABLE[i]);
                curPhase = int'(STIM_TABLE[i].phase);
            end
            applyRow(STIM_TABLE[i]);
        end
        drainPhase();
        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+sim
source/ccipPkg.sv
source/nicTxPkg.sv
source/flowFifo.sv
source/requestQueue.sv
source/batchScheduler.sv
source/clWriter.sv
source/ccipTransmitter.sv
sim/tbCcipTransmitter.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the transmit path testbench with Verilator and runs it into a log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module tbCcipTransmitter \
    -Mdir obj_dir -o simTb

./obj_dir/simTb | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation log is in sim.log"
